/* sources.f */
+incdir+rtl
rtl/i2c_pkg.sv
rtl/cfg_pkg.sv
rtl/queue_if.sv
rtl/xfer_queue.sv
rtl/cfg_sequencer.sv
rtl/i2c_byte_engine.sv
rtl/i2c_cfg_top.sv
testbench/i2c_slave_model.sv
testbench/tb_i2c_cfg.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_i2c_cfg
FILELIST := sources.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard rtl/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/tb_i2c_cfg.sv */
// the slave sits at CFG_DEV_ADDR and the burst test needs CFG_LEN > RES_DEPTH; 16 cycles per bit assumed
`timescale 1ns/100ps
`include "i2c_defines.svh"

module tb_i2c_cfg;

    typedef enum logic [2:0] {K_RESET, K_START, K_IDLE, K_WRITE, K_READ, K_BURST} kind_t;

    // expected read data is not stored here, it comes from the reference memory
    typedef struct packed {
        logic [2:0] test;
        kind_t      kind;
        logic [6:0] dev;
        logic [7:0] regn;
        logic       exp_nack;
        logic [7:0] xfers;
    } step_t;

    localparam int NSTEPS      = 13;
    localparam int NTESTS      = 5;
    localparam int BURST_LEN   = `RES_DEPTH + 1;
    localparam int WAIT_CYCLES = 16 * 45 * 16;

    // test, kind, device, register, expected nack, bus transfers the step may cause
    localparam step_t STEPS [NSTEPS] = '{
        '{3'd0, K_RESET, 7'h00,         8'h00, 1'b0, 8'd0},
        '{3'd1, K_START, 7'h00,         8'h00, 1'b0, 8'(`CFG_LEN)},
        '{3'd1, K_IDLE,  7'h00,         8'h00, 1'b0, 8'd0},
        '{3'd1, K_READ,  `CFG_DEV_ADDR, 8'h03, 1'b0, 8'd1},
        '{3'd1, K_READ,  `CFG_DEV_ADDR, 8'h10, 1'b0, 8'd1},
        '{3'd1, K_READ,  `CFG_DEV_ADDR, 8'h11, 1'b0, 8'd1},
        '{3'd1, K_READ,  `CFG_DEV_ADDR, 8'h1a, 1'b0, 8'd1},
        '{3'd1, K_READ,  `CFG_DEV_ADDR, 8'h1b, 1'b0, 8'd1},
        '{3'd2, K_WRITE, `CFG_DEV_ADDR, 8'h40, 1'b0, 8'd1},
        '{3'd2, K_READ,  `CFG_DEV_ADDR, 8'h40, 1'b0, 8'd1},
        '{3'd3, K_READ,  7'h50,         8'h03, 1'b1, 8'd1},
        '{3'd4, K_START, 7'h00,         8'h00, 1'b0, 8'(`CFG_LEN)},
        '{3'd4, K_BURST, `CFG_DEV_ADDR, 8'h00, 1'b0, 8'(BURST_LEN)}
    };

    string test_names [NTESTS] = '{
        "reset", "configuration walk", "host write and read back",
        "wrong device", "result back-pressure"
    };

    logic       clock;
    logic       arst_n;
    logic       start;
    logic       host_push;
    logic       host_rnw;
    logic [6:0] host_dev;
    logic [7:0] host_reg;
    logic [7:0] host_wdata;
    logic       host_full;
    logic       rd_pop;
    logic       rd_empty;
    logic [7:0] rd_reg;
    logic [7:0] rd_data;
    logic       rd_nack;
    logic       busy;
    logic       scl_oe;
    logic       sda_oe;
    logic       sda_pd;
    wire        scl;
    wire        sda;
    int         stop_count;
    logic [7:0] ref_mem [256];
    logic [31:0] lfsr;
    int         errors;
    int         err_mark;
    int         tests_passed;
    int         tests_failed;
    int         stops_base;

    // open-drain lines, either side can only pull low
    assign scl = !scl_oe;
    assign sda = !sda_oe && !sda_pd;

    i2c_cfg_top UUT (
        .clock      (clock),
        .arst_n     (arst_n),
        .start      (start),
        .host_push  (host_push),
        .host_rnw   (host_rnw),
        .host_dev   (host_dev),
        .host_reg   (host_reg),
        .host_wdata (host_wdata),
        .host_full  (host_full),
        .rd_pop     (rd_pop),
        .rd_empty   (rd_empty),
        .rd_reg     (rd_reg),
        .rd_data    (rd_data),
        .rd_nack    (rd_nack),
        .busy       (busy),
        .scl_in     (scl),
        .sda_in     (sda),
        .scl_oe     (scl_oe),
        .sda_oe     (sda_oe)
    );

    i2c_slave_model #(.ADDR(`CFG_DEV_ADDR)) u_slave (
        .scl        (scl),
        .sda        (sda),
        .sda_pd     (sda_pd),
        .stop_count (stop_count)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    // galois form of x^32 + x^22 + x^2 + x + 1, shifting right
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic random_byte(output logic [7:0] b);
        b = 8'h00;
        for (int i = 0; i < 8; i++) begin
            b    = {b[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_error(input string what);
        $display("ERROR %s", what);
        errors++;
    endtask

    // inputs always change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic wait_not_busy();
        int n;
        n = 0;
        while (busy && n < WAIT_CYCLES) begin
            next_cycle();
            n++;
        end
        if (busy) begin
            report_error("timed out waiting for busy to fall");
        end
    endtask

    task automatic push_request(input logic rnw, input logic [6:0] dev,
                                input logic [7:0] regn, input logic [7:0] wdata);
        int n;
        n = 0;
        while (host_full && n < WAIT_CYCLES) begin
            next_cycle();
            n++;
        end
        if (host_full) begin
            report_error("host request port never became free");
        end else begin
            host_push  = 1'b1;
            host_rnw   = rnw;
            host_dev   = dev;
            host_reg   = regn;
            host_wdata = wdata;
            next_cycle();
            host_push  = 1'b0;
            // the accepted request now sits in the holding register
            check("host_full", 8'(host_full), 8'h01);
        end
    endtask

    // a nacked transfer hands back zero data
    task automatic pop_result(input logic [7:0] regn, input logic exp_nack);
        logic [7:0] exp_data;
        int         n;
        exp_data = exp_nack ? 8'h00 : ref_mem[regn];
        n = 0;
        while (rd_empty && n < WAIT_CYCLES) begin
            next_cycle();
            n++;
        end
        if (rd_empty) begin
            report_error("no result arrived for a read");
        end else begin
            check("rd_reg", rd_reg, regn);
            check("rd_data", rd_data, exp_data);
            check("rd_nack", 8'(rd_nack), 8'(exp_nack));
            rd_pop = 1'b1;
            next_cycle();
            rd_pop = 1'b0;
        end
    endtask

    // reads pile up behind the walk until the engine stalls on a full result queue
    task automatic run_burst();
        int n;
        int target;
        target = stops_base + `CFG_LEN + BURST_LEN;
        for (int i = 0; i < BURST_LEN; i++) begin
            push_request(1'b1, `CFG_DEV_ADDR, cfg_pkg::CFG_TABLE[i].reg_addr, 8'h00);
        end
        n = 0;
        while (stop_count < target && n < WAIT_CYCLES * BURST_LEN) begin
            next_cycle();
            n++;
        end
        if (stop_count != target) begin
            report_error("bus transfers did not end right after the result queue filled");
        end
        // the last read waits inside the engine with both lines released
        check("scl_oe", 8'(scl_oe), 8'h00);
        check("sda_oe", 8'(sda_oe), 8'h00);
        check("busy", 8'(busy), 8'h01);
        for (int i = 0; i < BURST_LEN; i++) begin
            pop_result(cfg_pkg::CFG_TABLE[i].reg_addr, 1'b0);
        end
        wait_not_busy();
    endtask

    task automatic run_step(input step_t s);
        logic [7:0] wdata;
        case (s.kind)
            K_RESET: begin
                check("scl_oe", 8'(scl_oe), 8'h00);
                check("sda_oe", 8'(sda_oe), 8'h00);
                check("busy", 8'(busy), 8'h00);
                check("rd_empty", 8'(rd_empty), 8'h01);
                check("host_full", 8'(host_full), 8'h00);
            end
            K_START: begin
                stops_base = stop_count;
                start = 1'b1;
                next_cycle();
                start = 1'b0;
            end
            K_IDLE: begin
                wait_not_busy();
            end
            K_WRITE: begin
                random_byte(wdata);
                push_request(1'b0, s.dev, s.regn, wdata);
                if (s.dev == `CFG_DEV_ADDR) begin
                    ref_mem[s.regn] = wdata;
                end
                wait_not_busy();
            end
            K_READ: begin
                push_request(1'b1, s.dev, s.regn, 8'h00);
                pop_result(s.regn, s.exp_nack);
            end
            K_BURST: begin
                run_burst();
            end
            default: begin
                report_error("step table holds an unknown step kind");
            end
        endcase
    endtask

    task automatic report_test(input int t);
        if (errors == err_mark) begin
            tests_passed++;
            $display("test %0d (%s) done: ok", t, test_names[t]);
        end else begin
            tests_failed++;
            $display("test %0d (%s) done: %0d errors", t, test_names[t], errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        arst_n       = 1'b0;
        start        = 1'b0;
        host_push    = 1'b0;
        host_rnw     = 1'b0;
        host_dev     = 7'h00;
        host_reg     = 8'h00;
        host_wdata   = 8'h00;
        rd_pop       = 1'b0;
        lfsr         = 32'hb5745f25;
        errors       = 0;
        err_mark     = 0;
        tests_passed = 0;
        tests_failed = 0;
        stops_base   = 0;
        for (int a = 0; a < 256; a++) begin
            ref_mem[8'(a)] = 8'h00;
        end
        // later table entries overwrite earlier ones for the same register
        for (int e = 0; e < `CFG_LEN; e++) begin
            ref_mem[cfg_pkg::CFG_TABLE[e].reg_addr] = cfg_pkg::CFG_TABLE[e].data;
        end
        repeat (2) @(posedge clock);
        #1;
        arst_n = 1'b1;
        for (int i = 0; i < NSTEPS; i++) begin
            run_step(STEPS[i]);
            if (i == NSTEPS - 1 || STEPS[i + 1].test != STEPS[i].test) begin
                report_test(int'(STEPS[i].test));
            end
        end
        $display("%0d tests run: %0d passed, %0d failed, %0d errors",
                 tests_passed + tests_failed, tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // each bus transfer gets 45 bit times of 16 cycles at 10 ns
    initial begin
        longint limit;
        limit = 0;
        for (int i = 0; i < NSTEPS; i++) begin
            limit += longint'(STEPS[i].xfers);
        end
        limit = limit * 45 * 16 * 10;
        #(limit);
        $display("watchdog expired after %0d ns, the run did not finish", limit);
        $display("tests failed");
        $finish;
    end

endmodule

/* testbench/i2c_slave_model.sv */
// behavioral slave without clock stretching; one 7-bit address and a register pointer that increments
`timescale 1ns/100ps

module i2c_slave_model #(
    parameter logic [6:0] ADDR = 7'h62
) (
    input  logic scl,
    input  logic sda,
    output logic sda_pd,
    output int   stop_count
);

    typedef enum {P_IDLE, P_ADDR, P_REG, P_WDATA, P_RDATA, P_DONE} phase_t;

    phase_t     phase;
    logic [7:0] mem [256];
    logic [7:0] ptr;
    logic [7:0] sh;
    logic       rd_mode;
    logic       in_xfer;
    logic       scl_q;
    logic       sda_q;
    int         bitn;

    // data bits are shifted in on the rising scl edge
    task automatic on_rise();
        if (bitn < 8 && (phase == P_ADDR || phase == P_REG || phase == P_WDATA)) begin
            sh = {sh[6:0], sda};
        end
        // a high level in the ack slot after read data is the master's nack
        if (bitn == 8 && phase == P_RDATA && sda) begin
            phase = P_DONE;
        end
        bitn++;
    endtask

    // the slave only ever changes sda while scl is low
    task automatic on_fall();
        if (phase == P_IDLE || phase == P_DONE) begin
            sda_pd = 1'b0;
        end else if (bitn == 8) begin
            // the ack slot follows the eighth bit
            sda_pd = 1'b1;
            case (phase)
                P_ADDR: begin
                    rd_mode = sh[0];
                    if (sh[7:1] != ADDR) begin
                        sda_pd = 1'b0;
                        phase  = P_IDLE;
                    end
                end
                P_REG: begin
                    ptr = sh;
                end
                P_WDATA: begin
                    mem[ptr] = sh;
                    ptr++;
                end
                default: begin
                    // after read data the master owns the ack slot
                    sda_pd = 1'b0;
                end
            endcase
        end else if (bitn == 9) begin
            bitn   = 0;
            sda_pd = 1'b0;
            if (phase == P_ADDR) begin
                phase = rd_mode ? P_RDATA : P_REG;
            end else if (phase == P_REG) begin
                phase = P_WDATA;
            end
            if (phase == P_RDATA) begin
                sh     = mem[ptr];
                ptr++;
                sda_pd = !sh[7];
            end
        end else if (phase == P_RDATA) begin
            sda_pd = !sh[3'(7 - bitn)];
        end
    endtask

    initial begin
        sda_pd     = 1'b0;
        stop_count = 0;
        phase      = P_IDLE;
        ptr        = 8'h00;
        sh         = 8'h00;
        rd_mode    = 1'b0;
        in_xfer    = 1'b0;
        bitn       = 0;
        scl_q      = 1'b1;
        sda_q      = 1'b1;
        for (int a = 0; a < 256; a++) begin
            mem[8'(a)] = 8'(a) ^ 8'ha5;
        end
        forever begin
            @(scl or sda);
            if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b1 && sda === 1'b0) begin
                // start and repeated start both reopen the address phase
                phase   = P_ADDR;
                bitn    = 0;
                in_xfer = 1'b1;
                sda_pd  = 1'b0;
            end else if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b0 && sda === 1'b1) begin
                if (in_xfer) begin
                    stop_count++;
                end
                in_xfer = 1'b0;
                phase   = P_IDLE;
                sda_pd  = 1'b0;
            end else if (scl_q === 1'b0 && scl === 1'b1) begin
                on_rise();
            end else if (scl_q === 1'b1 && scl === 1'b0) begin
                on_fall();
            end
            scl_q = scl;
            sda_q = sda;
        end
    end

endmodule

/* rtl/i2c_cfg_top.sv */
// open-drain pads live outside; each oe pulls its line low and the inputs must carry the pad level
`timescale 1ns/100ps
`include "i2c_defines.svh"

module i2c_cfg_top (
    input  logic       clock,
    input  logic       arst_n,
    input  logic       start,
    input  logic       host_push,
    input  logic       host_rnw,
    input  logic [6:0] host_dev,
    input  logic [7:0] host_reg,
    input  logic [7:0] host_wdata,
    output logic       host_full,
    input  logic       rd_pop,
    output logic       rd_empty,
    output logic [7:0] rd_reg,
    output logic [7:0] rd_data,
    output logic       rd_nack,
    output logic       busy,
    input  logic       scl_in,
    input  logic       sda_in,
    output logic       scl_oe,
    output logic       sda_oe
);

    logic walking;
    logic eng_busy;

    queue_if #(.T(i2c_pkg::xfer_t))   cmd_q ();
    queue_if #(.T(i2c_pkg::result_t)) res_q ();

    cfg_sequencer u_sequencer (
        .clock      (clock),
        .arst_n     (arst_n),
        .start      (start),
        .host_push  (host_push),
        .host_rnw   (host_rnw),
        .host_dev   (host_dev),
        .host_reg   (host_reg),
        .host_wdata (host_wdata),
        .host_full  (host_full),
        .walking    (walking),
        .cmd        (cmd_q.producer)
    );

    xfer_queue #(
        .T     (i2c_pkg::xfer_t),
        .DEPTH (`CMD_DEPTH)
    ) u_cmd_queue (
        .clock  (clock),
        .arst_n (arst_n),
        .q      (cmd_q.queue)
    );

    i2c_byte_engine u_engine (
        .clock  (clock),
        .arst_n (arst_n),
        .scl_in (scl_in),
        .sda_in (sda_in),
        .scl_oe (scl_oe),
        .sda_oe (sda_oe),
        .busy   (eng_busy),
        .cmd    (cmd_q.consumer),
        .res    (res_q.producer)
    );

    xfer_queue #(
        .T     (i2c_pkg::result_t),
        .DEPTH (`RES_DEPTH)
    ) u_res_queue (
        .clock  (clock),
        .arst_n (arst_n),
        .q      (res_q.queue)
    );

    // the host is the consumer of the result queue
    assign res_q.rd_en = rd_pop;
    assign rd_empty    = res_q.empty;
    assign rd_reg      = res_q.rd_data.reg_addr;
    assign rd_data     = res_q.rd_data.rdata;
    assign rd_nack     = res_q.rd_data.nack;

    // unread results also count as outstanding work
    assign busy = walking || host_full || !cmd_q.empty || !res_q.empty || eng_busy;

endmodule

/* rtl/i2c_byte_engine.sv */
// single master without clock stretching; SDA is sampled only while scl_in is really high
`timescale 1ns/100ps
`include "i2c_defines.svh"

module i2c_byte_engine (
    input  logic      clock,
    input  logic      arst_n,
    input  logic      scl_in,
    input  logic      sda_in,
    output logic      scl_oe,
    output logic      sda_oe,
    output logic      busy,
    queue_if.consumer cmd,
    queue_if.producer res
);

    localparam int DW = $clog2(`I2C_QUARTER + 1);
    localparam logic [DW-1:0] DIV_LAST = DW'(`I2C_QUARTER - 1);

    i2c_pkg::eng_state_t state;
    i2c_pkg::xfer_t      cur;
    logic [DW-1:0]       div;
    logic [1:0]          qtr;
    logic [2:0]          bitcnt;
    logic [1:0]          byte_n;
    logic [7:0]          shreg;
    logic                slave_nack;
    logic                nack;
    logic                tick;
    logic                stall;
    logic                sample;
    logic                phase_end;
    logic                rx;
    logic                need_res;

    assign tick = div == DIV_LAST;

    // byte 0 is the device, 1 the register, 2 write data or device again, 3 read data
    assign rx       = cur.rnw && byte_n == 2'd3;
    assign need_res = cur.rnw || nack;

    // the last stop quarter holds with both lines released until a result fits
    assign stall     = state == i2c_pkg::ST_STOP && qtr == 2'd3 && need_res && res.full;
    assign sample    = tick && qtr == 2'd2 && scl_in;
    assign phase_end = tick && qtr == 2'd3 && !stall;

    assign busy      = state != i2c_pkg::ST_IDLE;
    assign cmd.rd_en = state == i2c_pkg::ST_IDLE && !cmd.empty;

    // phase_end already implies room in the result queue
    assign res.wr_en   = state == i2c_pkg::ST_STOP && phase_end && need_res;
    assign res.wr_data = '{
        reg_addr: cur.reg_addr,
        rdata:    nack ? 8'h00 : shreg,
        nack:     nack
    };

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state      <= i2c_pkg::ST_IDLE;
            div        <= '0;
            qtr        <= '0;
            bitcnt     <= '0;
            byte_n     <= '0;
            nack       <= 1'b0;
            slave_nack <= 1'b0;
        end else begin
            div <= tick ? '0 : div + 1'b1;
            if (tick && !stall) begin
                qtr <= qtr + 1'b1;
            end
            if (sample && state == i2c_pkg::ST_ACK) begin
                slave_nack <= sda_in;
            end

            case (state)
                i2c_pkg::ST_IDLE: begin
                    // restart the divider so the first quarter has full length
                    if (cmd.rd_en) begin
                        state  <= i2c_pkg::ST_START;
                        div    <= '0;
                        qtr    <= '0;
                        bitcnt <= '0;
                        byte_n <= '0;
                        nack   <= 1'b0;
                    end
                end
                i2c_pkg::ST_START, i2c_pkg::ST_RSTART: begin
                    if (phase_end) begin
                        state <= i2c_pkg::ST_SHIFT;
                    end
                end
                i2c_pkg::ST_SHIFT: begin
                    // bitcnt wraps back to zero after the eighth bit
                    if (phase_end) begin
                        bitcnt <= bitcnt + 1'b1;
                        if (bitcnt == 3'd7) begin
                            state <= i2c_pkg::ST_ACK;
                        end
                    end
                end
                i2c_pkg::ST_ACK: begin
                    if (phase_end) begin
                        if (!rx && slave_nack) begin
                            nack  <= 1'b1;
                            state <= i2c_pkg::ST_STOP;
                        end else if (rx || (!cur.rnw && byte_n == 2'd2)) begin
                            state <= i2c_pkg::ST_STOP;
                        end else if (cur.rnw && byte_n == 2'd1) begin
                            state  <= i2c_pkg::ST_RSTART;
                            byte_n <= 2'd2;
                        end else begin
                            state  <= i2c_pkg::ST_SHIFT;
                            byte_n <= byte_n + 1'b1;
                        end
                    end
                end
                i2c_pkg::ST_STOP: begin
                    if (phase_end) begin
                        state <= i2c_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state <= i2c_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // outgoing bytes leave msb first, the read byte is shifted in at the sample point
    always_ff @(posedge clock) begin
        if (cmd.rd_en) begin
            cur <= cmd.rd_data;
        end
        if (sample && state == i2c_pkg::ST_SHIFT && rx) begin
            shreg <= {shreg[6:0], sda_in};
        end else if (phase_end) begin
            case (state)
                i2c_pkg::ST_START:  shreg <= {cur.dev, 1'b0};
                i2c_pkg::ST_RSTART: shreg <= {cur.dev, 1'b1};
                i2c_pkg::ST_SHIFT: begin
                    if (!rx) begin
                        shreg <= {shreg[6:0], 1'b0};
                    end
                end
                i2c_pkg::ST_ACK: begin
                    // the received byte must survive into the result
                    if (!rx) begin
                        shreg <= (byte_n == 2'd0) ? cur.reg_addr
                                                  : (cur.rnw ? 8'h00 : cur.wdata);
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // scl is low in quarters 0 and 3 of a bit, high in 1 and 2
    // an asserted enable pulls the line low
    always_comb begin
        scl_oe = 1'b0;
        sda_oe = 1'b0;
        case (state)
            i2c_pkg::ST_START: begin
                scl_oe = qtr == 2'd3;
                sda_oe = qtr[1];
            end
            i2c_pkg::ST_RSTART: begin
                scl_oe = qtr == 2'd0 || qtr == 2'd3;
                sda_oe = qtr[1];
            end
            i2c_pkg::ST_SHIFT: begin
                scl_oe = qtr == 2'd0 || qtr == 2'd3;
                sda_oe = !rx && !shreg[7];
            end
            i2c_pkg::ST_ACK: begin
                // sda stays released, the master always answers the read byte with nack
                scl_oe = qtr == 2'd0 || qtr == 2'd3;
            end
            i2c_pkg::ST_STOP: begin
                scl_oe = qtr == 2'd0;
                sda_oe = !qtr[1];
            end
            default: begin
            end
        endcase
    end

    // a command is only taken once the previous stop has left both bus lines high
    a_pop_idle: assert property (@(posedge clock) disable iff (!arst_n)
        cmd.rd_en |-> scl_in && sda_in);

    // a data bit must hold still while scl is released
    a_sda_stable: assert property (@(posedge clock) disable iff (!arst_n)
        state == i2c_pkg::ST_SHIFT && (qtr == 2'd1 || qtr == 2'd2) |-> $stable(sda_oe));

endmodule

/* rtl/cfg_sequencer.sv */
// one pending host request at a time; table entries win over host requests while the walk runs
`timescale 1ns/100ps
`include "i2c_defines.svh"

module cfg_sequencer (
    input  logic       clock,
    input  logic       arst_n,
    input  logic       start,
    input  logic       host_push,
    input  logic       host_rnw,
    input  logic [6:0] host_dev,
    input  logic [7:0] host_reg,
    input  logic [7:0] host_wdata,
    output logic       host_full,
    output logic       walking,
    queue_if.producer  cmd
);

    localparam int IW = $clog2(`CFG_LEN + 1);
    localparam logic [IW-1:0] LAST = IW'(`CFG_LEN - 1);

    logic [IW-1:0]       idx;
    logic                host_valid;
    logic                host_take;
    i2c_pkg::xfer_t      host_req;
    i2c_pkg::xfer_t      table_cmd;
    cfg_pkg::cfg_entry_t entry;

    // table writes always go to the clock chip
    assign entry     = cfg_pkg::CFG_TABLE[idx];
    assign table_cmd = '{
        rnw:      1'b0,
        dev:      `CFG_DEV_ADDR,
        reg_addr: entry.reg_addr,
        wdata:    entry.data
    };

    // a host request is taken only when the holding register is free
    assign host_take = host_push && !host_valid;
    assign host_full = host_valid;

    // the walk owns the queue until its last entry is in
    assign cmd.wr_en   = (walking || host_valid) && !cmd.full;
    assign cmd.wr_data = walking ? table_cmd : host_req;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            walking    <= 1'b0;
            idx        <= '0;
            host_valid <= 1'b0;
        end else begin
            // start pulses during a walk are ignored
            if (start && !walking) begin
                walking <= 1'b1;
                idx     <= '0;
            end else if (walking && !cmd.full) begin
                idx <= idx + 1'b1;
                if (idx == LAST) begin
                    walking <= 1'b0;
                end
            end

            // the pending request leaves in the first cycle the walk and the queue allow
            if (host_take) begin
                host_valid <= 1'b1;
            end else if (host_valid && !walking && !cmd.full) begin
                host_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (host_take) begin
            host_req <= '{
                rnw:      host_rnw,
                dev:      host_dev,
                reg_addr: host_reg,
                wdata:    host_wdata
            };
        end
    end

    // a second start mid-walk must not rewind the table
    a_no_restart: assert property (@(posedge clock) disable iff (!arst_n)
        (walking && start && idx != '0) |=> idx != '0);

endmodule

/* rtl/xfer_queue.sv */
// DEPTH must be a power of two and at least 2; head data is undefined while empty
`timescale 1ns/100ps

module xfer_queue #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input logic    clock,
    input logic    arst_n,
    queue_if.queue q
);

    localparam int AW = $clog2(DEPTH);

    T               mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [AW:0]    count;
    logic [AW:0]    count_nxt;
    logic           do_wr;
    logic           do_rd;

    // flags are registered, so a qualified strobe never depends on its own result
    assign do_wr = q.wr_en && !q.full;
    assign do_rd = q.rd_en && !q.empty;

    assign count_nxt = count + (AW + 1)'(do_wr) - (AW + 1)'(do_rd);

    // first word falls through, the head is read straight from the array
    assign q.rd_data = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= q.wr_data;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            q.full  <= 1'b0;
            q.empty <= 1'b1;
        end else begin
            // pointers wrap on their own because DEPTH is a power of two
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count   <= count_nxt;
            q.full  <= count_nxt == (AW + 1)'(DEPTH);
            q.empty <= count_nxt == '0;
        end
    end

    // producers in this design look at full before writing
    a_no_write_full: assert property (@(posedge clock) disable iff (!arst_n)
        q.full |-> !q.wr_en);

    // the consumer only pops a word it has already seen
    a_no_read_empty: assert property (@(posedge clock) disable iff (!arst_n)
        q.empty |-> !q.rd_en);

endmodule

/* rtl/queue_if.sv */
// no handshake beyond full and empty; a producer must not write while full, a consumer not pop while empty
`timescale 1ns/100ps

interface queue_if #(
    parameter type T = logic [7:0]
);

    // write side
    logic wr_en;
    T     wr_data;
    logic full;

    // read side, rd_data always shows the head word
    logic rd_en;
    T     rd_data;
    logic empty;

    modport producer (
        output wr_en,
        output wr_data,
        input  full
    );

    modport consumer (
        output rd_en,
        input  rd_data,
        input  empty
    );

    // the storage itself owns the flags and the head word
    modport queue (
        input  wr_en,
        input  wr_data,
        output full,
        input  rd_en,
        output rd_data,
        output empty
    );

endinterface

/* rtl/cfg_pkg.sv */
// table length comes from CFG_LEN and every entry goes to CFG_DEV_ADDR; entries are written in order
`include "i2c_defines.svh"

package cfg_pkg;

    // one register write of the power-up walk
    typedef struct packed {
        logic [7:0] reg_addr;
        logic [7:0] data;
    } cfg_entry_t;

    // power-up settings for the clock chip
    // outputs are held disabled first and then enabled once the dividers are set
    localparam cfg_entry_t CFG_TABLE [`CFG_LEN] = '{
        '{reg_addr: 8'h03, data: 8'hff},
        '{reg_addr: 8'h10, data: 8'h4f},
        '{reg_addr: 8'h11, data: 8'h4f},
        '{reg_addr: 8'h1a, data: 8'h00},
        '{reg_addr: 8'h1b, data: 8'h01},
        '{reg_addr: 8'h03, data: 8'hfc}
    };

endpackage

/* rtl/i2c_pkg.sv */
// single-byte register transfers only; one command always gives at most one result word
package i2c_pkg;

    // one register transfer as queued by the sequencer
    // the device address is 7 bits and the engine appends the r/w bit itself
    typedef struct packed {
        logic       rnw;
        logic [6:0] dev;
        logic [7:0] reg_addr;
        logic [7:0] wdata;
    } xfer_t;

    // what the engine hands back to the host
    // rdata is zero whenever nack is set, since no data byte was taken from the slave
    typedef struct packed {
        logic [7:0] reg_addr;
        logic [7:0] rdata;
        logic       nack;
    } result_t;

    // bus phases of the byte engine, each one lasts four quarter periods
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_SHIFT,
        ST_ACK,
        ST_RSTART,
        ST_STOP
    } eng_state_t;

endpackage

/* rtl/i2c_defines.svh */
// build-time constants only; queue depths must be powers of two and the bit rate is fixed here
`ifndef I2C_DEFINES_SVH
`define I2C_DEFINES_SVH

// system clock cycles in one quarter of an scl period, so one bit takes four times this
`define I2C_QUARTER 4

// depth of the transfer command queue between the sequencer and the engine
`define CMD_DEPTH 4

// depth of the result queue that the host drains
`define RES_DEPTH 4

// number of register writes in the power-up configuration walk
`define CFG_LEN 6

// 7-bit address of the clock chip that the configuration walk targets
`define CFG_DEV_ADDR 7'h62

`endif
